// ==== verilog/rv_fetch_settings.svh ====
`ifndef RV_FETCH_SETTINGS_SVH
`define RV_FETCH_SETTINGS_SVH

// program counter width in bits
`define RV_ADDR_W 32

// one 32-bit word per line
`define RV_ICACHE_LINES 8

// program memory depth in words
`define RV_ROM_WORDS 64

// cycles from read strobe to valid data
`define RV_ROM_LATENCY 2

`endif

// ==== verilog/rv_fetch_pkg.sv ====
`include "rv_fetch_settings.svh"

package rv_fetch_pkg;

    typedef logic [`RV_ADDR_W-1:0] addr_t;
    typedef logic [31:0] word_t;

    // major opcodes the fetch stage cares about
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // J-type layout, immediate bits scattered as in the ISA
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fields_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fields_t;

    // one instruction word, decoded either way
    typedef union packed {
        word_t     raw;
        j_fields_t j_fields;
        i_fields_t i_fields;
    } inst_u;

    typedef struct packed {
        logic  en;
        addr_t target;
    } redirect_t;

    typedef struct packed {
        logic  valid;
        addr_t pc;
        inst_u inst;
    } fetch_slot_t;

    typedef struct packed {
        logic  en;
        addr_t pc;
    } icache_req_t;

    // word is still in memory byte order
    typedef struct packed {
        logic  hit;
        word_t word;
    } icache_rsp_t;

    typedef struct packed {
        logic  valid;
        word_t word;
    } rom_rsp_t;

endpackage

// ==== verilog/instr_fetch.sv ====
`timescale 1ns/1ns
`include "rv_fetch_settings.svh"

module instr_fetch (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      issue,

    // redirects from the ALU and the branch unit
    input  rv_fetch_pkg::redirect_t   jump0,
    input  rv_fetch_pkg::redirect_t   jump1,
    input  rv_fetch_pkg::redirect_t   branch,

    // cache lookup
    output rv_fetch_pkg::icache_req_t cache_req,
    input  rv_fetch_pkg::icache_rsp_t cache_rsp,

    // to the decoder
    output rv_fetch_pkg::fetch_slot_t slot
);

    rv_fetch_pkg::addr_t pc;
    logic                issue_q;
    logic                jump_stall;
    logic                branch_wait;
    logic                stalled;

    rv_fetch_pkg::inst_u inst;
    rv_fetch_pkg::word_t j_imm;
    logic                is_jal;
    logic                is_jalr;
    logic                is_branch;

    logic                take;
    logic                jump_en;
    logic                load_slot;
    rv_fetch_pkg::addr_t jump_target;
    rv_fetch_pkg::addr_t seq_pc;
    rv_fetch_pkg::addr_t next_pc;

    logic                slot_valid;
    rv_fetch_pkg::addr_t slot_pc;
    rv_fetch_pkg::inst_u slot_inst;

    // no lookups while waiting on a jump or branch outcome
    assign stalled   = jump_stall || branch_wait;
    assign cache_req = '{en: !stalled, pc: pc};

    // byte 0 of the instruction sits in the top byte of the memory word
    assign inst.raw = {cache_rsp.word[7:0], cache_rsp.word[15:8],
                       cache_rsp.word[23:16], cache_rsp.word[31:24]};

    assign is_jal    = inst.j_fields.opcode == rv_fetch_pkg::OPC_JAL;
    assign is_jalr   = inst.i_fields.opcode == rv_fetch_pkg::OPC_JALR &&
                       inst.i_fields.funct3 == 3'b000;
    assign is_branch = inst.i_fields.opcode == rv_fetch_pkg::OPC_BRANCH;

    // reassemble the scattered J immediate, sign extended
    assign j_imm = {{11{inst.j_fields.imm20}}, inst.j_fields.imm20,
                    inst.j_fields.imm19_12, inst.j_fields.imm11,
                    inst.j_fields.imm10_1, 1'b0};

    assign seq_pc  = pc + rv_fetch_pkg::addr_t'(3'd4);
    assign next_pc = is_jal ? pc + rv_fetch_pkg::addr_t'(j_imm) : seq_pc;

    // jump0 has priority over jump1
    assign jump_en     = jump0.en || jump1.en;
    assign jump_target = jump0.en ? jump0.target : jump1.target;

    assign take      = issue_q && cache_rsp.hit && !stalled;
    assign load_slot = take && !branch.en && !jump_en;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc          <= '0;
            issue_q     <= 1'b0;
            jump_stall  <= 1'b0;
            branch_wait <= 1'b0;
            slot_valid  <= 1'b0;
        end else begin
            issue_q    <= issue;
            slot_valid <= 1'b0;
            if (branch.en) begin
                pc          <= branch.target;
                branch_wait <= 1'b0;
            end else if (jump_en) begin
                pc         <= jump_target;
                jump_stall <= 1'b0;
            end else if (take) begin
                pc          <= next_pc;
                slot_valid  <= 1'b1;
                // hold until the ALU or branch unit resolves it
                jump_stall  <= is_jalr;
                branch_wait <= is_branch;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_slot) begin
            slot_pc   <= pc;
            slot_inst <= inst;
        end
    end

    assign slot = '{valid: slot_valid, pc: slot_pc, inst: slot_inst};

endmodule

// ==== verilog/icache.sv ====
`timescale 1ns/1ns
`include "rv_fetch_settings.svh"

module icache (
    input  logic                                clk,
    input  logic                                rst,

    // lookup from fetch
    input  rv_fetch_pkg::icache_req_t           req,
    output rv_fetch_pkg::icache_rsp_t           rsp,

    // refill from the ROM
    output logic                                rd_en,
    output logic [$clog2(`RV_ROM_WORDS)-1:0]    rd_index,
    input  rv_fetch_pkg::rom_rsp_t              fill
);

    localparam int INDEX_W   = $clog2(`RV_ICACHE_LINES);
    localparam int TAG_W     = `RV_ADDR_W - INDEX_W - 2;
    localparam int ROM_IDX_W = $clog2(`RV_ROM_WORDS);

    // line storage
    logic [`RV_ICACHE_LINES-1:0] line_valid;
    logic [TAG_W-1:0]            line_tag  [`RV_ICACHE_LINES];
    rv_fetch_pkg::word_t         line_data [`RV_ICACHE_LINES];

    logic [INDEX_W-1:0]          req_index;
    logic [TAG_W-1:0]            req_tag;
    logic                        hit;
    logic                        start_refill;
    logic                        fill_done;

    // outstanding refill
    logic                        refill_busy;
    logic [INDEX_W-1:0]          refill_index;
    logic [TAG_W-1:0]            refill_tag;

    // word address modulo line count
    assign req_index = req.pc[INDEX_W+1:2];
    assign req_tag   = req.pc[`RV_ADDR_W-1:INDEX_W+2];

    assign hit = req.en && line_valid[req_index] && line_tag[req_index] == req_tag;
    assign rsp = '{hit: hit, word: line_data[req_index]};

    // only one refill in flight; a new pc waits until it lands
    assign start_refill = req.en && !hit && !refill_busy;
    assign fill_done    = refill_busy && fill.valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            line_valid  <= '0;
            refill_busy <= 1'b0;
            rd_en       <= 1'b0;
        end else begin
            rd_en <= start_refill;
            if (start_refill) begin
                refill_busy <= 1'b1;
            end else if (fill_done) begin
                refill_busy              <= 1'b0;
                line_valid[refill_index] <= 1'b1;
            end
        end
    end

    // miss address capture
    always_ff @(posedge clk) begin
        if (start_refill) begin
            refill_index <= req_index;
            refill_tag   <= req_tag;
            rd_index     <= req.pc[ROM_IDX_W+1:2];
        end
    end

    always_ff @(posedge clk) begin
        if (fill_done) begin
            line_tag[refill_index]  <= refill_tag;
            line_data[refill_index] <= fill.word;
        end
    end

endmodule

// ==== verilog/instr_rom.sv ====
`timescale 1ns/1ns
`include "rv_fetch_settings.svh"

module instr_rom (
    input  logic                             clk,
    input  logic                             rst,

    // load port, used while in reset
    input  logic                             prog_we,
    input  logic [$clog2(`RV_ROM_WORDS)-1:0] prog_addr,
    input  rv_fetch_pkg::word_t              prog_data,

    // read port
    input  logic                             rd_en,
    input  logic [$clog2(`RV_ROM_WORDS)-1:0] rd_index,
    output rv_fetch_pkg::rom_rsp_t           data
);

    localparam int LAT = `RV_ROM_LATENCY;

    rv_fetch_pkg::word_t mem [`RV_ROM_WORDS];

    logic [LAT-1:0]      valid_pipe;
    rv_fetch_pkg::word_t word_pipe [LAT];

    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_data;
        end
    end

    // read strobe travels alongside the word
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe[0] <= rd_en;
            for (int i = 1; i < LAT; i++) begin
                valid_pipe[i] <= valid_pipe[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        word_pipe[0] <= mem[rd_index];
        for (int i = 1; i < LAT; i++) begin
            word_pipe[i] <= word_pipe[i-1];
        end
    end

    assign data = '{valid: valid_pipe[LAT-1], word: word_pipe[LAT-1]};

endmodule

// ==== verilog/fetch_top.sv ====
`timescale 1ns/1ns
`include "rv_fetch_settings.svh"

module fetch_top (
    input  logic                             clk,
    input  logic                             rst,

    // program load
    input  logic                             prog_we,
    input  logic [$clog2(`RV_ROM_WORDS)-1:0] prog_addr,
    input  rv_fetch_pkg::word_t              prog_data,

    input  logic                             issue,
    input  rv_fetch_pkg::redirect_t          jump0,
    input  rv_fetch_pkg::redirect_t          jump1,
    input  rv_fetch_pkg::redirect_t          branch,

    output rv_fetch_pkg::fetch_slot_t        slot
);

    rv_fetch_pkg::icache_req_t        cache_req;
    rv_fetch_pkg::icache_rsp_t        cache_rsp;
    rv_fetch_pkg::rom_rsp_t           rom_rsp;
    logic                             rd_en;
    logic [$clog2(`RV_ROM_WORDS)-1:0] rd_index;

    instr_fetch u_fetch (
        .clk       (clk),
        .rst       (rst),
        .issue     (issue),
        .jump0     (jump0),
        .jump1     (jump1),
        .branch    (branch),
        .cache_req (cache_req),
        .cache_rsp (cache_rsp),
        .slot      (slot)
    );

    icache u_icache (
        .clk      (clk),
        .rst      (rst),
        .req      (cache_req),
        .rsp      (cache_rsp),
        .rd_en    (rd_en),
        .rd_index (rd_index),
        .fill     (rom_rsp)
    );

    instr_rom u_rom (
        .clk       (clk),
        .rst       (rst),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .rd_en     (rd_en),
        .rd_index  (rd_index),
        .data      (rom_rsp)
    );

endmodule

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen (
    input  logic hold,
    output logic clk,
    output logic rst
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reset stays up while the program loads, then 2 more cycles
    initial begin
        rst = 1'b1;
        #1;
        wait (hold == 1'b0);
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// ==== dv/fetch_tb.sv ====
`timescale 1ns/1ns
`include "rv_fetch_settings.svh"

module fetch_tb;

    localparam int MAX_DELAY  = 6;
    localparam int MAX_LOW    = 5;
    localparam int SLOT_TOTAL = 12 + 150 + 130 + 150;
    localparam int CYCLE_LIMIT = SLOT_TOTAL * (`RV_ROM_LATENCY + 4)
                               + SLOT_TOTAL * (MAX_DELAY + MAX_LOW) + 200;
    localparam logic [31:0] LOOP_START = 32'd160;
    localparam logic [31:0] LOOP_END   = 32'd184;

    logic                      clk;
    logic                      rst;
    logic                      hold;
    logic                      prog_we;
    logic [5:0]                prog_addr;
    rv_fetch_pkg::word_t       prog_data;
    logic                      issue;
    rv_fetch_pkg::redirect_t   jump0;
    rv_fetch_pkg::redirect_t   jump1;
    rv_fetch_pkg::redirect_t   branch;
    rv_fetch_pkg::fetch_slot_t slot;

    // program in instruction order
    logic [31:0] prog [`RV_ROM_WORDS];

    // reference model state
    logic [31:0] model_pc;
    int          wait_kind;
    int          delay_left;
    bit          force_loop;
    bit          issue_prev;
    bit          fresh_reset;
    int          tests_ok;
    int          tests_bad;
    int          cycles;

    tb_clock_gen clock_gen (
        .hold (hold),
        .clk  (clk),
        .rst  (rst)
    );

    fetch_top dut (
        .clk       (clk),
        .rst       (rst),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .issue     (issue),
        .jump0     (jump0),
        .jump1     (jump1),
        .branch    (branch),
        .slot      (slot)
    );

    function automatic logic [31:0] byte_swap(input logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    // J immediate as laid out in the ISA
    function automatic logic [31:0] j_offset(input logic [31:0] w);
        return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    endfunction

    function automatic logic [31:0] make_jal(input int words);
        logic [20:0] o;
        o = 21'(words * 4);
        return {o[20], o[10:1], o[11], o[19:12], 5'($urandom), 7'b1101111};
    endfunction

    function automatic logic [31:0] make_alu();
        logic [6:0] opc [4];
        opc[0] = 7'b0010011;
        opc[1] = 7'b0110011;
        opc[2] = 7'b0110111;
        opc[3] = 7'b0000011;
        return {25'($urandom), opc[$urandom % 4]};
    endfunction

    function automatic logic [31:0] make_jalr();
        return {12'($urandom), 5'($urandom), 3'b000, 5'($urandom), 7'b1100111};
    endfunction

    function automatic logic [31:0] make_branch();
        return {25'($urandom), 7'b1100011};
    endfunction

    // random word target outside the loop block
    function automatic logic [31:0] pick_target();
        int r;
        r = $urandom % 57;
        if (r >= 40) begin
            r = r + 7;
        end
        return 32'(r * 4);
    endfunction

    task automatic build_program();
        int r;
        int lim;
        for (int w = 0; w < `RV_ROM_WORDS; w++) begin
            lim = (w < 39) ? 39 : 63;
            r = $urandom % 10;
            if (w < 12 || (w >= 40 && w <= 45)) begin
                prog[w] = make_alu();
            end else if (w == 39 || w == 63) begin
                prog[w] = make_jalr();
            end else if (w == 46) begin
                // backward jump closing a 7-word loop
                prog[w] = make_jal(-6);
            end else if (r == 6 && w + 4 <= lim) begin
                prog[w] = make_jal(2 + int'($urandom % 3));
            end else if (r == 7) begin
                prog[w] = make_jalr();
            end else if (r == 8) begin
                prog[w] = make_branch();
            end else begin
                prog[w] = make_alu();
            end
        end
    endtask

    task automatic compare_slot(input string name, inout int errs);
        logic [31:0] exp_inst;
        exp_inst = prog[model_pc[7:2]];
        assert (wait_kind == 0) else begin
            $display("%s: valid slot at pc %h while waiting for a redirect", name, slot.pc);
            errs++;
        end
        assert (slot.pc == model_pc) else begin
            $display("[ERROR] %s: pc expected %h actual %h", name, model_pc, slot.pc);
            errs++;
        end
        assert (slot.inst.raw == exp_inst) else begin
            $display("[ERROR] %s: inst expected %h actual %h", name, exp_inst,
                     slot.inst.raw);
            errs++;
        end
        if (exp_inst[6:0] == rv_fetch_pkg::OPC_JAL) begin
            model_pc = model_pc + j_offset(exp_inst);
        end else if (exp_inst[6:0] == rv_fetch_pkg::OPC_JALR && exp_inst[14:12] == 3'b000) begin
            wait_kind  = 1;
            delay_left = $urandom % MAX_DELAY;
        end else if (exp_inst[6:0] == rv_fetch_pkg::OPC_BRANCH) begin
            wait_kind  = 2;
            delay_left = $urandom % MAX_DELAY;
        end else begin
            model_pc = model_pc + 32'd4;
        end
    endtask

    // pulse the redirect that the stall is waiting for
    task automatic send_resolve();
        logic [31:0] tgt;
        int          sel;
        tgt = force_loop ? LOOP_START : pick_target();
        force_loop = 1'b0;
        sel = $urandom % 3;
        if (wait_kind == 1) begin
            if (sel == 1) begin
                jump1 = '{en: 1'b1, target: tgt};
            end else begin
                jump0 = '{en: 1'b1, target: tgt};
                if (sel == 2) begin
                    jump1 = '{en: 1'b1, target: pick_target()};
                end
            end
        end else begin
            branch = '{en: 1'b1, target: tgt};
            if (sel != 0) begin
                jump0 = '{en: 1'b1, target: pick_target()};
            end
        end
        model_pc  = tgt;
        wait_kind = 0;
    endtask

    task automatic run_test(input string name, input int n_slots, input bit drops,
                            input bit loop_mode);
        int got;
        int errs;
        int low_left;
        int loop_slots;
        int cycle_no;
        bit escaped;
        logic [31:0] tgt;
        got        = 0;
        errs       = 0;
        low_left   = 0;
        loop_slots = 0;
        cycle_no   = 0;
        escaped    = !loop_mode;
        force_loop = loop_mode;
        while (got < n_slots || !escaped) begin
            @(negedge clk);
            cycle_no++;
            jump0  = '0;
            jump1  = '0;
            branch = '0;
            if (slot.valid) begin
                // the first slot needs a ROM read behind the empty cache
                if (fresh_reset) begin
                    assert (cycle_no >= `RV_ROM_LATENCY + 2) else begin
                        $display("%s: first slot came %0d cycles after reset, before a refill",
                                 name, cycle_no);
                        errs++;
                    end
                    fresh_reset = 1'b0;
                end
                if (slot.pc >= LOOP_START && slot.pc <= LOOP_END) begin
                    loop_slots++;
                end
                compare_slot(name, errs);
                got++;
            end
            // issue sampled low one edge earlier blocks this slot
            assert (!(slot.valid && !issue_prev)) else begin
                $display("%s: a slot appeared although issue was low", name);
                errs++;
            end
            issue_prev = issue;
            if (drops) begin
                if (low_left > 0) begin
                    low_left--;
                    issue = 1'b0;
                end else if ($urandom % 8 == 0) begin
                    low_left = 1 + int'($urandom % MAX_LOW);
                    issue    = 1'b0;
                end else begin
                    issue = 1'b1;
                end
            end else begin
                issue = 1'b1;
            end
            if (wait_kind != 0) begin
                if (delay_left > 0) begin
                    delay_left--;
                end else begin
                    send_resolve();
                end
            end else if (!escaped && loop_slots >= 24) begin
                // leave the loop with a jump while nothing is stalled
                tgt     = pick_target();
                jump0   = '{en: 1'b1, target: tgt};
                model_pc = tgt;
                escaped = 1'b1;
            end
        end
        $display("test %s: %0d slots, %0d errors, %s", name, got, errs,
                 (errs == 0) ? "ok" : "FAIL");
        if (errs == 0) begin
            tests_ok++;
        end else begin
            tests_bad++;
        end
    endtask

    // cycle watchdog
    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: slots stopped arriving after %0d cycles", cycles);
        $display("Test failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h08f8_4356));
        hold        = 1'b1;
        prog_we     = 1'b0;
        prog_addr   = '0;
        prog_data   = '0;
        issue       = 1'b0;
        jump0       = '0;
        jump1       = '0;
        branch      = '0;
        model_pc    = '0;
        wait_kind   = 0;
        delay_left  = 0;
        force_loop  = 1'b0;
        issue_prev  = 1'b0;
        fresh_reset = 1'b1;
        tests_ok    = 0;
        tests_bad   = 0;
        build_program();

        // ROM holds words in memory byte order
        for (int w = 0; w < `RV_ROM_WORDS; w++) begin
            @(negedge clk);
            prog_we   = 1'b1;
            prog_addr = 6'(w);
            prog_data = byte_swap(prog[w]);
        end
        @(negedge clk);
        prog_we = 1'b0;
        hold    = 1'b0;
        issue   = 1'b1;
        // rst changes on the falling edge, so look at it on the rising one
        while (rst) begin
            @(posedge clk);
        end

        run_test("straight_line", 12, 1'b0, 1'b0);
        run_test("jal_jalr_branch", 150, 1'b0, 1'b0);
        run_test("cache_loop", 60, 1'b0, 1'b1);
        run_test("issue_backpressure", 150, 1'b1, 1'b0);

        $display("tests: %0d run, %0d ok, %0d with errors", tests_ok + tests_bad,
                 tests_ok, tests_bad);
        if (tests_bad == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== rv_fetch.f ====
+incdir+verilog
verilog/rv_fetch_pkg.sv
verilog/instr_fetch.sv
verilog/icache.sv
verilog/instr_rom.sv
verilog/fetch_top.sv
dv/tb_clock_gen.sv
dv/fetch_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the fetch stage testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module fetch_tb \
    -f rv_fetch.f --Mdir obj_dir -o fetch_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "build error, see build.log"
    exit 1
fi

./obj_dir/fetch_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" sim.log; then
    exit 1
fi
if ! grep -q "Test passed" sim.log; then
    echo "no result line in sim.log"
    exit 1
fi
exit 0
